/* all.f */
+incdir+.
fetch_pkg.sv
fetch_mem.sv
mem_arbiter.sv
fetch_unit.sv
inst_bank.sv
inst_align.sv
fetch_top.sv
tb_fetch_assert.sv
tb_fetch.sv

/* run.sh */
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal --top-module tb_fetch \
  -f all.f -o tb_fetch_sim
./obj_dir/tb_fetch_sim | tee sim.log

if grep -q "All tests passed" sim.log; then
  echo "simulation PASSED"
  exit 0
else
  echo "simulation FAILED"
  exit 1
fi

/* tb_fetch.sv */
`timescale 1ns/1ps

module tb_fetch;

  localparam int timeout_cycles = 4000;
  localparam int aw = fetch_pkg::mem_aw;

  logic clock;
  logic reset;
  logic redirect;
  logic [31:0] redirect_pc;
  logic issue_stall;
  fetch_pkg::mem_req_t data_req;
  fetch_pkg::mem_rsp_t data_rsp;
  fetch_pkg::issue_slot_t slot0;
  fetch_pkg::issue_slot_t slot1;
  logic fetch_full;

  logic [63:0] model_word [2**aw];  // what the testbench has written to memory
  fetch_pkg::issue_slot_t exp_q[$];
  logic [15:0] prog_q[$];
  fetch_pkg::mem_rsp_t rsp_exp;
  bit rsp_due;
  bit rsp_known;
  int errors;
  int tests_failed;
  int test_count;
  int cycles;
  int long_left;

  fetch_top dut (
    .clock (clock),
    .reset (reset),
    .redirect (redirect),
    .redirect_pc (redirect_pc),
    .issue_stall (issue_stall),
    .data_req (data_req),
    .data_rsp (data_rsp),
    .slot0 (slot0),
    .slot1 (slot1),
    .fetch_full (fetch_full)
  );

  initial clock = 1'b0;
  always #50 clock = ~clock;

  always @(posedge clock) begin
    cycles++;
    if (cycles >= timeout_cycles) begin
      $display("Timeout: the run did not finish within %0d cycles", timeout_cycles);
      $display("Some tests failed");
      $finish;
    end
  end

  function automatic fetch_pkg::mem_req_t make_req(bit req, bit we, int addr, logic [63:0] d);
    fetch_pkg::mem_req_t r;
    r.req = req;
    r.we = we;
    r.addr = aw'(addr);
    r.wdata = d;
    return r;
  endfunction

  function automatic logic [15:0] half_at(logic [31:0] pc);
    return model_word[pc[aw+2:3]][16*pc[2:1] +: 16];
  endfunction

  // walks the written halfwords with the length rule
  function automatic void build_expected(logic [31:0] pc, int n);
    fetch_pkg::instr_word_u w;
    fetch_pkg::issue_slot_t e;
    exp_q.delete();
    for (int i = 0; i < n; i++) begin
      w.half.lo = half_at(pc);
      w.half.hi = half_at(pc + 2);
      e.valid = 1'b1;
      e.pc = pc;
      if (w.raw[1:0] != 2'b11) begin
        e.instr = {16'h0000, w.half.lo};
        pc = pc + 2;
      end else begin
        e.instr = w.raw;
        pc = pc + 4;
      end
      exp_q.push_back(e);
    end
  endfunction

  task automatic check_slot(input string name, input fetch_pkg::issue_slot_t got,
                            input fetch_pkg::issue_slot_t exp);
    if (got !== exp) begin
      $display("Error: %s valid %h pc %h instr %h, expected valid %h pc %h instr %h",
               name, got.valid, got.pc, got.instr, exp.valid, exp.pc, exp.instr);
      errors++;
    end
  endtask

  task automatic check_rsp(input string name, input fetch_pkg::mem_rsp_t got,
                           input fetch_pkg::mem_rsp_t exp, input bit data_known);
    if (got.valid !== exp.valid || (data_known && got.rdata !== exp.rdata)) begin
      $display("Error: %s valid %h rdata %h, expected valid %h rdata %h",
               name, got.valid, got.rdata, exp.valid, exp.rdata);
      errors++;
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("Error: %s %h, expected %h", name, got, exp);
      errors++;
    end
  endtask

  // one clock: drive on the falling edge, sample just before the rising edge
  task automatic cycle(input fetch_pkg::mem_req_t req, input logic redir,
                       input logic [31:0] rpc, input logic stall);
    fetch_pkg::issue_slot_t e;
    fetch_pkg::issue_slot_t idle;
    fetch_pkg::mem_rsp_t none;
    @(negedge clock);
    data_req = req;
    redirect = redir;
    if (redir) begin
      redirect_pc = rpc;
    end
    issue_stall = stall;
    #40;
    idle.valid = 1'b0;
    idle.pc = '1;
    idle.instr = '0;
    none.valid = 1'b0;
    none.rdata = '0;
    if (!slot0.valid) begin
      check_slot("slot0", slot0, idle);
    end else if (exp_q.size() > 0) begin
      e = exp_q.pop_front();
      check_slot("slot0", slot0, e);
    end
    if (!slot1.valid) begin
      check_slot("slot1", slot1, idle);
    end else if (exp_q.size() > 0) begin
      e = exp_q.pop_front();
      check_slot("slot1", slot1, e);
    end
    if (rsp_due) begin
      check_rsp("data_rsp", data_rsp, rsp_exp, rsp_known);
    end else begin
      check_rsp("data_rsp", data_rsp, none, 1'b0);
    end
    rsp_due = req.req;
    rsp_known = req.req && !req.we;  // a write only has to answer with valid
    rsp_exp.valid = 1'b1;
    rsp_exp.rdata = model_word[req.addr];
    if (req.req && req.we) begin
      model_word[req.addr] = req.wdata;
    end
  endtask

  task automatic idle_cycle();
    cycle(make_req(0, 0, 0, '0), 1'b0, 32'h0, 1'b0);
  endtask

  task automatic gen_program(input int n, input bit only32);
    fetch_pkg::instr_word_u w;
    prog_q.delete();
    for (int i = 0; i < n; i++) begin
      w.raw = $urandom;
      if (!only32 && $urandom % 2 == 1) begin
        w.half.lo[1:0] = 2'($urandom % 3);  // compressed
        prog_q.push_back(w.half.lo);
      end else begin
        w.half.lo[1:0] = 2'b11;
        prog_q.push_back(w.half.lo);
        prog_q.push_back(w.half.hi);
      end
    end
    while (prog_q.size() % 4 != 0) begin
      prog_q.push_back(16'h0001);
    end
  endtask

  task automatic load_program(input int base);
    for (int i = 0; i < prog_q.size() / 4; i++) begin
      cycle(make_req(1, 1, base + i, {prog_q[4*i+3], prog_q[4*i+2],
                                      prog_q[4*i+1], prog_q[4*i]}), 1'b0, 32'h0, 1'b0);
    end
  endtask

  task automatic start_stream(input logic [31:0] pc, input int n);
    build_expected(pc, n);
    cycle(make_req(0, 0, 0, '0), 1'b1, pc, 1'b0);
  endtask

  // runs until only left instructions are still expected
  task automatic collect(input int left, input bit stalls, input bit traffic);
    fetch_pkg::mem_req_t r;
    logic st;
    bit long_done;
    int a;
    while (exp_q.size() > left) begin
      r = make_req(0, 0, 0, '0);
      st = 1'b0;
      long_done = 1'b0;
      if (stalls) begin
        if (long_left > 0) begin
          st = 1'b1;
          long_left--;
          long_done = (long_left == 0);
        end else begin
          a = $urandom % 20;
          if (a == 0) begin
            long_left = 40;  // long enough to fill the buffer
          end
          st = (a < 6);
        end
      end
      if (traffic && $urandom % 3 == 0) begin
        if ($urandom % 2 == 1) begin
          r = make_req(1, 1, 240 + $urandom % 16, {$urandom, $urandom});
        end else if ($urandom % 2 == 1) begin
          r = make_req(1, 0, 240 + $urandom % 16, '0);
        end else begin
          r = make_req(1, 0, $urandom % (prog_q.size() / 4), '0);
        end
      end
      cycle(r, 1'b0, 32'h0, st);
      if (long_done) begin
        // nothing was consumed for 41 cycles so the buffer has filled up
        check_flag("fetch_full", fetch_full, 1'b1);
      end
    end
    idle_cycle();
  endtask

  task automatic finish_test(input string name, input int errs_before);
    test_count++;
    if (errors == errs_before) begin
      $display("PASS  %s", name);
    end else begin
      tests_failed++;
      $display("FAIL  %s (%0d errors)", name, errors - errs_before);
    end
  endtask

  task automatic test_data_port();
    int e0;
    e0 = errors;
    for (int i = 0; i < 16; i++) begin
      cycle(make_req(1, 1, 200 + i, {$urandom, $urandom}), 1'b0, 32'h0, 1'b0);
    end
    for (int i = 0; i < 16; i++) begin
      cycle(make_req(1, 0, 200 + i, '0), 1'b0, 32'h0, 1'b0);
    end
    idle_cycle();
    finish_test("data port writes and reads", e0);
  endtask

  task automatic test_aligned_stream();
    int e0;
    e0 = errors;
    gen_program(32, 1'b1);
    load_program(0);
    start_stream(32'h0, 32);
    collect(0, 1'b0, 1'b0);
    finish_test("32-bit stream from pc 0", e0);
  endtask

  task automatic test_mixed_stream();
    int e0;
    e0 = errors;
    gen_program(64, 1'b0);
    load_program(32);
    start_stream(32'd256, 64);
    collect(0, 1'b0, 1'b0);
    finish_test("mixed 16/32-bit stream", e0);
  endtask

  task automatic test_redirect();
    int e0;
    e0 = errors;
    gen_program(48, 1'b0);
    load_program(64);
    start_stream(32'd512 + 2, 16);  // bits 2:1 equal 1
    collect(6, 1'b0, 1'b0);
    start_stream(32'd512 + 32 + 6, 16);  // mid-stream, bits 2:1 equal 3
    collect(0, 1'b0, 1'b0);
    finish_test("redirect to unaligned targets", e0);
  endtask

  task automatic test_stalls();
    int e0;
    e0 = errors;
    long_left = 0;
    gen_program(80, 1'b0);
    load_program(128);
    start_stream(32'd1024, 80);
    collect(0, 1'b1, 1'b0);
    finish_test("random issue stalls", e0);
  endtask

  task automatic test_interleaved();
    int e0;
    e0 = errors;
    for (int i = 0; i < 16; i++) begin
      cycle(make_req(1, 1, 240 + i, {$urandom, $urandom}), 1'b0, 32'h0, 1'b0);
    end
    gen_program(48, 1'b0);
    load_program(0);
    start_stream(32'h0, 48);
    collect(0, 1'b0, 1'b1);
    finish_test("data traffic during fetch", e0);
  endtask

  initial begin
    void'($urandom(53));
    reset = 1'b0;
    redirect = 1'b0;
    redirect_pc = '0;
    issue_stall = 1'b0;
    data_req = '0;
    errors = 0;
    tests_failed = 0;
    test_count = 0;
    cycles = 0;
    rsp_due = 1'b0;
    rsp_known = 1'b0;
    rsp_exp = '0;
    long_left = 0;
    repeat (4) @(negedge clock);
    reset = 1'b1;

    test_data_port();
    test_aligned_stream();
    test_mixed_stream();
    test_redirect();
    test_stalls();
    test_interleaved();

    $display("%0d tests run, %0d failed, %0d errors", test_count, tests_failed, errors);
    if (errors == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

/* tb_fetch_assert.sv */
`timescale 1ns/1ps

module tb_fetch_assert (
  input logic clock,
  input logic reset,
  input logic redirect,
  input fetch_pkg::mem_req_t data_req,
  input fetch_pkg::mem_rsp_t data_rsp,
  input fetch_pkg::issue_slot_t slot0,
  input fetch_pkg::issue_slot_t slot1
);

  slot_order: assert property (@(posedge clock) disable iff (!reset)
    slot1.valid |-> slot0.valid)
    else $error("slot1 valid while slot0 is invalid");

  // exactly one response per data request, one cycle later
  data_rsp_timing: assert property (@(posedge clock) disable iff (!reset)
    data_req.req |=> data_rsp.valid)
    else $error("data_rsp.valid missing one cycle after data_req.req");

  data_rsp_spurious: assert property (@(posedge clock) disable iff (!reset)
    !data_req.req |=> !data_rsp.valid)
    else $error("data_rsp.valid without a data request");

  quiet_after_redirect: assert property (@(posedge clock) disable iff (!reset)
    redirect |=> !slot0.valid && !slot1.valid)
    else $error("slot valid in the cycle after redirect");

endmodule

bind fetch_top tb_fetch_assert u_fetch_assert (
  .clock (clock),
  .reset (reset),
  .redirect (redirect),
  .data_req (data_req),
  .data_rsp (data_rsp),
  .slot0 (slot0),
  .slot1 (slot1)
);

/* fetch_top.sv */
`timescale 1ns/1ps

module fetch_top (
  input logic clock,
  input logic reset,
  input logic redirect,
  input logic [31:0] redirect_pc,
  input logic issue_stall,
  input fetch_pkg::mem_req_t data_req,
  output fetch_pkg::mem_rsp_t data_rsp,
  output fetch_pkg::issue_slot_t slot0,
  output fetch_pkg::issue_slot_t slot1,
  output logic fetch_full
);

  fetch_pkg::mem_req_t fetch_req;
  fetch_pkg::mem_req_t mem_req;
  fetch_pkg::mem_rsp_t mem_rsp;
  fetch_pkg::mem_rsp_t fetch_rsp;
  fetch_pkg::fetch_line_t line;
  fetch_pkg::bank_wr_t bank_wr;
  fetch_pkg::bank_rd_t bank_rd;
  logic fetch_grant;
  logic clear;

  fetch_unit u_fetch_unit (
    .clock (clock),
    .reset (reset),
    .redirect (redirect),
    .redirect_pc (redirect_pc),
    .fetch_full (fetch_full),
    .fetch_grant (fetch_grant),
    .fetch_req (fetch_req),
    .fetch_rsp (fetch_rsp),
    .line (line),
    .clear (clear)
  );

  mem_arbiter u_mem_arbiter (
    .clock (clock),
    .reset (reset),
    .data_req (data_req),
    .fetch_req (fetch_req),
    .fetch_grant (fetch_grant),
    .mem_req (mem_req),
    .mem_rsp (mem_rsp),
    .data_rsp (data_rsp),
    .fetch_rsp (fetch_rsp)
  );

  fetch_mem u_fetch_mem (
    .clock (clock),
    .mem_req (mem_req),
    .mem_rsp (mem_rsp)
  );

  inst_align u_inst_align (
    .clock (clock),
    .reset (reset),
    .line (line),
    .clear (clear),
    .issue_stall (issue_stall),
    .bank_wr (bank_wr),
    .bank_rd (bank_rd),
    .slot0 (slot0),
    .slot1 (slot1),
    .fetch_full (fetch_full)
  );

  inst_bank u_inst_bank (
    .clock (clock),
    .bank_wr (bank_wr),
    .bank_rd (bank_rd)
  );

endmodule

/* inst_align.sv */
`timescale 1ns/1ps
`include "fetch_settings.svh"

module inst_align (
  input logic clock,
  input logic reset,
  input fetch_pkg::fetch_line_t line,
  input logic clear,
  input logic issue_stall,
  output fetch_pkg::bank_wr_t bank_wr,
  input fetch_pkg::bank_rd_t bank_rd,
  output fetch_pkg::issue_slot_t slot0,
  output fetch_pkg::issue_slot_t slot1,
  output logic fetch_full
);

  localparam int aw = fetch_pkg::buf_aw;
  localparam int cap = 4 * `FETCH_BUF_LINES;  // capacity in halfwords

  logic [aw-1:0] wid_q;  // next line slot to write
  logic [aw+1:0] rid_q;  // next halfword to issue
  logic [aw+2:0] count_q;  // halfwords held
  logic first_q;  // the next line opens a new stream

  logic wr;
  logic [1:0] skip;
  logic [2:0] fill;
  logic [aw+1:0] rid;
  logic [aw+2:0] count;
  fetch_pkg::half_entry_t [3:0] win;
  fetch_pkg::instr_word_u [2:0] word;
  logic [2:0] comp;
  logic [1:0] len0;
  logic [1:0] len1;
  logic v0;
  logic v1;
  logic [2:0] used;

  always_comb begin
    wr = line.valid & ~clear;
    skip = (wr && first_q) ? line.pc[2:1] : 2'd0;  // halfwords before the redirect target
    fill = wr ? 3'd4 - {1'b0, skip} : 3'd0;
    rid = rid_q + {{aw{1'b0}}, skip};  // rid_q is zero while first_q is set
    count = count_q + {{aw{1'b0}}, fill};  // an arriving line counts at once

    bank_wr.we = {4{wr}};
    bank_wr.waddr = wid_q;
    for (int k = 0; k < 4; k++) begin
      bank_wr.wdata[k].pc = {line.pc[31:3], k[1:0], 1'b0};
      bank_wr.wdata[k].half = line.data[16*k +: 16];
      // banks below the window start are read from the following line
      bank_wr.raddr[k] = rid[aw+1:2] + aw'(k < rid[1:0]);
    end

    for (int k = 0; k < 4; k++) begin
      win[k] = bank_rd.rdata[2'(rid[1:0] + k)];
    end

    for (int k = 0; k < 3; k++) begin
      word[k].half.lo = win[k].half;
      word[k].half.hi = win[k+1].half;
      comp[k] = ~&word[k].raw[1:0];
    end

    len0 = comp[0] ? 2'd1 : 2'd2;
    len1 = comp[len0] ? 2'd1 : 2'd2;

    // the count is tested first so halfwords not yet written are never decoded
    v0 = (count > 0) && (comp[0] || count > 1);
    v1 = v0 && (count > len0) && (comp[len0] || count > len0 + 1);
    if (issue_stall || clear) begin
      v0 = 1'b0;
      v1 = 1'b0;
    end

    used = (v0 ? {1'b0, len0} : 3'd0) + (v1 ? {1'b0, len1} : 3'd0);
  end

  always_comb begin
    slot0.valid = v0;
    slot0.pc = '1;
    slot0.instr = '0;
    if (v0) begin
      slot0.pc = win[0].pc;
      slot0.instr = comp[0] ? {16'h0000, word[0].half.lo} : word[0].raw;
    end

    slot1.valid = v1;
    slot1.pc = '1;
    slot1.instr = '0;
    if (v1) begin
      slot1.pc = win[len0].pc;
      slot1.instr = comp[len0] ? {16'h0000, word[len0].half.lo} : word[len0].raw;
    end
  end

  always_ff @(posedge clock) begin
    if (!reset || clear) begin
      wid_q <= '0;
      rid_q <= '0;
      count_q <= '0;
      first_q <= 1'b1;
    end else begin
      if (wr) begin
        wid_q <= wid_q + 1'b1;
        first_q <= 1'b0;
      end
      rid_q <= rid + {{(aw-1){1'b0}}, used};
      count_q <= count - {{aw{1'b0}}, used};
    end
  end

  // leaves room for the one line that may still be in flight
  assign fetch_full = count_q > cap - 8;

endmodule

/* inst_bank.sv */
`timescale 1ns/1ps
`include "fetch_settings.svh"

module inst_bank (
  input logic clock,
  input fetch_pkg::bank_wr_t bank_wr,
  output fetch_pkg::bank_rd_t bank_rd
);

  // bank b holds halfword b of every buffered line
  fetch_pkg::half_entry_t bank [4][`FETCH_BUF_LINES];

  always_ff @(posedge clock) begin
    for (int b = 0; b < 4; b++) begin
      if (bank_wr.we[b]) begin
        bank[b][bank_wr.waddr] <= bank_wr.wdata[b];
      end
    end
  end

  // each bank has its own read address so a window can start at any halfword
  always_comb begin
    for (int b = 0; b < 4; b++) begin
      if (bank_wr.we[b] && bank_wr.raddr[b] == bank_wr.waddr) begin
        bank_rd.rdata[b] = bank_wr.wdata[b];  // the line written on this edge
      end else begin
        bank_rd.rdata[b] = bank[b][bank_wr.raddr[b]];
      end
    end
  end

endmodule

/* fetch_unit.sv */
`timescale 1ns/1ps
`include "fetch_settings.svh"

module fetch_unit (
  input logic clock,
  input logic reset,
  input logic redirect,
  input logic [31:0] redirect_pc,
  input logic fetch_full,
  input logic fetch_grant,
  output fetch_pkg::mem_req_t fetch_req,
  input fetch_pkg::mem_rsp_t fetch_rsp,
  output fetch_pkg::fetch_line_t line,
  output logic clear
);

  logic [31:0] line_pc_q;  // keeps bits 2:1 of a redirect target until that line is granted
  logic [31:0] line_pc_next;
  logic [31:0] rsp_pc_q;  // pc of the line whose response is due next cycle
  logic drop_q;

  // the buffer always has room for the line in flight when this is issued
  always_comb begin
    fetch_req.req = ~fetch_full;
    fetch_req.we = 1'b0;
    fetch_req.addr = line_pc_q[fetch_pkg::mem_aw+2:3];
    fetch_req.wdata = '0;
  end

  always_comb begin
    line_pc_next = line_pc_q;
    if (redirect) begin
      line_pc_next = redirect_pc;
    end else if (fetch_grant) begin
      line_pc_next = {line_pc_q[31:3], 3'b000} + 32'd8;
    end
  end

  always_ff @(posedge clock) begin
    if (!reset) begin
      line_pc_q <= `FETCH_RESET_PC;
      drop_q <= 1'b0;
    end else begin
      line_pc_q <= line_pc_next;
      drop_q <= redirect & fetch_grant;  // this response still belongs to the old stream
    end
  end

  always_ff @(posedge clock) begin
    if (fetch_grant) begin
      rsp_pc_q <= line_pc_q;
    end
  end

  // a response arriving with the redirect itself is stale as well
  always_comb begin
    line.valid = fetch_rsp.valid & ~drop_q & ~redirect;
    line.pc = rsp_pc_q;
    line.data = fetch_rsp.rdata;
  end

  assign clear = redirect;

endmodule

/* mem_arbiter.sv */
`timescale 1ns/1ps

module mem_arbiter (
  input logic clock,
  input logic reset,
  input fetch_pkg::mem_req_t data_req,
  input fetch_pkg::mem_req_t fetch_req,
  output logic fetch_grant,
  output fetch_pkg::mem_req_t mem_req,
  input fetch_pkg::mem_rsp_t mem_rsp,
  output fetch_pkg::mem_rsp_t data_rsp,
  output fetch_pkg::mem_rsp_t fetch_rsp
);

  logic [1:0] owner_q;  // bit 0 is the data port, bit 1 the fetch unit, zero when idle

  assign fetch_grant = fetch_req.req & ~data_req.req;  // the data port always wins

  always_comb begin
    if (data_req.req) begin
      mem_req = data_req;
    end else begin
      mem_req = fetch_req;
    end
  end

  always_ff @(posedge clock) begin
    if (!reset) begin
      owner_q <= 2'b00;
    end else begin
      owner_q <= {fetch_grant, data_req.req};
    end
  end

  // the memory answers one cycle later, so the registered owner steers the response
  always_comb begin
    data_rsp.valid = mem_rsp.valid & owner_q[0];
    data_rsp.rdata = mem_rsp.rdata;
    fetch_rsp.valid = mem_rsp.valid & owner_q[1];
    fetch_rsp.rdata = mem_rsp.rdata;
  end

endmodule

/* fetch_mem.sv */
`timescale 1ns/1ps
`include "fetch_settings.svh"

module fetch_mem (
  input logic clock,
  input fetch_pkg::mem_req_t mem_req,
  output fetch_pkg::mem_rsp_t mem_rsp
);

  logic [63:0] ram [`FETCH_MEM_WORDS];
  logic [63:0] rdata_q;
  logic valid_q;

  always_ff @(posedge clock) begin
    if (mem_req.req) begin
      if (mem_req.we) begin
        ram[mem_req.addr] <= mem_req.wdata;
      end
      rdata_q <= ram[mem_req.addr];  // a write returns the old contents
    end
  end

  // every request gets exactly one response, reads and writes alike
  always_ff @(posedge clock) begin
    valid_q <= mem_req.req;
  end

  always_comb begin
    mem_rsp.valid = valid_q;
    mem_rsp.rdata = rdata_q;
  end

endmodule

/* fetch_pkg.sv */
`include "fetch_settings.svh"

package fetch_pkg;

  localparam int buf_aw = $clog2(`FETCH_BUF_LINES);
  localparam int mem_aw = $clog2(`FETCH_MEM_WORDS);

  typedef struct packed {
    logic req;
    logic we;
    logic [mem_aw-1:0] addr;  // word index into the memory
    logic [63:0] wdata;
  } mem_req_t;

  typedef struct packed {
    logic valid;
    logic [63:0] rdata;
  } mem_rsp_t;

  typedef struct packed {
    logic valid;
    logic [31:0] pc;  // bits 2:1 are only set on the first line of a stream
    logic [63:0] data;
  } fetch_line_t;

  typedef struct packed {
    logic [31:0] pc;  // line pc with the offset of this halfword filled in
    logic [15:0] half;
  } half_entry_t;

  typedef struct packed {
    logic [3:0] we;
    logic [buf_aw-1:0] waddr;
    half_entry_t [3:0] wdata;
    logic [3:0][buf_aw-1:0] raddr;
  } bank_wr_t;

  typedef struct packed {
    half_entry_t [3:0] rdata;
  } bank_rd_t;

  typedef struct packed {
    logic valid;
    logic [31:0] pc;
    logic [31:0] instr;
  } issue_slot_t;

  typedef struct packed {
    logic [15:0] hi;
    logic [15:0] lo;
  } instr_half_t;

  typedef union packed {
    logic [31:0] raw;
    instr_half_t half;
  } instr_word_u;

endpackage

/* fetch_settings.svh */
`ifndef FETCH_SETTINGS_SVH
`define FETCH_SETTINGS_SVH

// entries in each of the four halfword banks
// any power of two of 4 or more works
`define FETCH_BUF_LINES 16

// number of 64-bit words in the unified memory
`define FETCH_MEM_WORDS 256

// first fetch pc after reset
`define FETCH_RESET_PC 32'h0000_0000

`endif
